// ==== hw/conv1x1_params.svh ====
`ifndef CONV1X1_PARAMS_SVH
`define CONV1X1_PARAMS_SVH

//////////////////////////////////////////////////
// Datapath sizes

// Input channels per pixel
`define NUM_CH 8
// Pixel element and weight width
`define DATA_W 16
// Room for NUM_CH full-scale products
`define ACC_W 40
// Weight FIFO entries, power of two
`define FIFO_DEPTH 16

//////////////////////////////////////////////////
// APB register map
`define APB_AW 8
`define REG_WEIGHT 8'h00
`define REG_CTRL 8'h04
`define REG_STATUS 8'h08

`endif

// ==== hw/conv1x1_pkg.sv ====
package conv1x1_pkg;

`include "conv1x1_params.svh"

	// Signed datapath words
	typedef logic signed [`DATA_W-1:0] data_t;
	typedef logic signed [`DATA_W-1:0] weight_t;
	typedef logic signed [`ACC_W-1:0] acc_t;

	// Channel select, 0 to NUM_CH-1
	typedef logic [$clog2(`NUM_CH)-1:0] ch_idx_t;
	// Occupancy 0 to FIFO_DEPTH, one extra bit
	typedef logic [$clog2(`FIFO_DEPTH):0] fifo_cnt_t;

	// APB bus words
	typedef logic [`APB_AW-1:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Weight loader
	typedef enum logic {
		LD_IDLE,
		LD_DRAIN
	} load_state_t;

endpackage

// ==== hw/conv1x1_weight_fifo.sv ====
`timescale 1ns/100ps

`include "conv1x1_params.svh"

module conv1x1_weight_fifo import conv1x1_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      push,
	input  logic      pop,
	input  weight_t   din,
	output weight_t   dout,
	output fifo_cnt_t count,
	output logic      full,
	output logic      empty
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);

	// Storage, no reset needed
	weight_t mem [`FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign full  = (count == fifo_cnt_t'(`FIFO_DEPTH));
	assign empty = (count == '0);

	// Drop push on full, pop on empty
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Head word visible without read latency
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap, depth is a power of two
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== hw/conv1x1_weight_buffer.sv ====
`timescale 1ns/100ps

`include "conv1x1_params.svh"

module conv1x1_weight_buffer import conv1x1_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      wt_push,
	input  logic      load_req,
	input  weight_t   wt_data,
	output weight_t   w0,
	output weight_t   w1,
	output weight_t   w2,
	output weight_t   w3,
	output weight_t   w4,
	output weight_t   w5,
	output weight_t   w6,
	output weight_t   w7,
	output logic      weights_ready,
	output logic      loading,
	output logic      ovf_pulse,
	output logic      load_err_pulse,
	output fifo_cnt_t fifo_count
);

	localparam ch_idx_t LAST_CH = ch_idx_t'(`NUM_CH - 1);

	logic        stage_valid;
	weight_t     stage_data;
	weight_t     fifo_dout;
	fifo_cnt_t   fifo_occ;
	logic        fifo_full;
	logic        fifo_empty;
	logic        fifo_pop;
	load_state_t ld_state;
	ch_idx_t     ld_ch;
	logic        load_ok;
	weight_t     wfile [`NUM_CH];

	//////////////////////////////////////////////////
	// Input register stage

	// Staged word counts as occupied
	assign fifo_count = fifo_occ + fifo_cnt_t'(stage_valid);
	assign ovf_pulse  = wt_push && (fifo_count >= fifo_cnt_t'(`FIFO_DEPTH));

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= wt_push && !ovf_pulse;
		end
	end

	always_ff @(posedge clk) begin
		stage_data <= wt_data;
	end

	conv1x1_weight_fifo weight_fifo_inst (
		.clk   (clk),
		.reset (reset),
		.push  (stage_valid && !fifo_full),
		.pop   (fifo_pop),
		.din   (stage_data),
		.dout  (fifo_dout),
		.count (fifo_occ),
		.full  (fifo_full),
		.empty (fifo_empty)
	);

	//////////////////////////////////////////////////
	// Loader FSM

	// Requests during a drain are ignored
	assign load_ok        = (fifo_count >= fifo_cnt_t'(`NUM_CH));
	assign load_err_pulse = load_req && (ld_state == LD_IDLE) && !load_ok;
	assign loading        = (ld_state == LD_DRAIN);
	assign fifo_pop       = loading && !fifo_empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			ld_state      <= LD_IDLE;
			ld_ch         <= '0;
			weights_ready <= 1'b0;
		end else begin
			case (ld_state)
				LD_IDLE: begin
					if (load_req && load_ok) begin
						ld_state      <= LD_DRAIN;
						ld_ch         <= '0;
						weights_ready <= 1'b0;
					end
				end
				LD_DRAIN: begin
					ld_ch <= ld_ch + 1'b1;
					// Last word lands, weights usable next cycle
					if (ld_ch == LAST_CH) begin
						ld_state      <= LD_IDLE;
						weights_ready <= 1'b1;
					end
				end
				default: ld_state <= LD_IDLE;
			endcase
		end
	end

	// Weight file, one word per drain cycle in FIFO order
	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			wfile[ld_ch] <= fifo_dout;
		end
	end

	assign w0 = wfile[0];
	assign w1 = wfile[1];
	assign w2 = wfile[2];
	assign w3 = wfile[3];
	assign w4 = wfile[4];
	assign w5 = wfile[5];
	assign w6 = wfile[6];
	assign w7 = wfile[7];

endmodule

// ==== hw/conv1x1_apb_regs.sv ====
`timescale 1ns/100ps

`include "conv1x1_params.svh"

module conv1x1_apb_regs import conv1x1_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	output logic      wt_push,
	output logic      load_req,
	output weight_t   wt_data,
	input  logic      weights_ready,
	input  logic      loading,
	input  logic      ovf_pulse,
	input  logic      load_err_pulse,
	input  fifo_cnt_t fifo_count
);

	logic      access;
	logic      wr_access;
	logic      mapped;
	logic      ctrl_wr;
	logic      ovf_sticky;
	logic      lerr_sticky;
	apb_data_t status;

	//////////////////////////////////////////////////
	// Access phase decode

	// No wait states
	assign pready    = 1'b1;
	assign access    = psel && penable;
	assign wr_access = access && pwrite;
	assign ctrl_wr   = wr_access && (paddr == `REG_CTRL);

	assign mapped = (paddr == `REG_WEIGHT) || (paddr == `REG_CTRL) ||
		(paddr == `REG_STATUS);
	assign pslverr = access && !mapped;

	// Weight enters the input stage on the completing edge
	assign wt_push = wr_access && (paddr == `REG_WEIGHT);
	assign wt_data = weight_t'(pwdata[`DATA_W-1:0]);

	// Registered, loader sees it the cycle after completion
	always_ff @(posedge clk) begin
		if (reset) begin
			load_req <= 1'b0;
		end else begin
			load_req <= ctrl_wr && pwdata[0];
		end
	end

	//////////////////////////////////////////////////
	// Sticky error bits, clear wins over a new pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			ovf_sticky  <= 1'b0;
			lerr_sticky <= 1'b0;
		end else if (ctrl_wr && pwdata[2]) begin
			ovf_sticky  <= 1'b0;
			lerr_sticky <= 1'b0;
		end else begin
			ovf_sticky  <= ovf_sticky | ovf_pulse;
			lerr_sticky <= lerr_sticky | load_err_pulse;
		end
	end

	// STATUS layout
	always_comb begin
		status        = '0;
		status[0]     = weights_ready;
		status[1]     = loading;
		status[2]     = ovf_sticky;
		status[3]     = lerr_sticky;
		status[12:8]  = fifo_count;
	end

	// Other addresses read back zero
	assign prdata = (access && !pwrite && (paddr == `REG_STATUS)) ? status : '0;

endmodule

// ==== hw/conv1x1_mac.sv ====
`timescale 1ns/100ps

`include "conv1x1_params.svh"

module conv1x1_mac import conv1x1_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    pix_valid,
	input  logic    weights_ready,
	input  data_t   pix_data,
	input  weight_t w0,
	input  weight_t w1,
	input  weight_t w2,
	input  weight_t w3,
	input  weight_t w4,
	input  weight_t w5,
	input  weight_t w6,
	input  weight_t w7,
	output logic    pix_ready,
	output logic    out_valid,
	output acc_t    out_data
);

	localparam ch_idx_t LAST_CH = ch_idx_t'(`NUM_CH - 1);

	weight_t                     w_arr [`NUM_CH];
	ch_idx_t                     ch;
	acc_t                        acc;
	acc_t                        acc_next;
	logic signed [2*`DATA_W-1:0] prod;
	logic                        accept;

	assign w_arr[0] = w0;
	assign w_arr[1] = w1;
	assign w_arr[2] = w2;
	assign w_arr[3] = w3;
	assign w_arr[4] = w4;
	assign w_arr[5] = w5;
	assign w_arr[6] = w6;
	assign w_arr[7] = w7;

	// Stall pixels until a weight set is loaded
	assign pix_ready = weights_ready;
	assign accept    = pix_valid && pix_ready;

	//////////////////////////////////////////////////
	// Multiply and accumulate
	assign prod     = pix_data * w_arr[ch];
	// Channel 0 starts a fresh sum
	assign acc_next = (ch == '0) ? acc_t'(prod) : acc + prod;

	always_ff @(posedge clk) begin
		if (reset || !weights_ready) begin
			ch        <= '0;
			acc       <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= accept && (ch == LAST_CH);
			if (accept) begin
				acc <= acc_next;
				ch  <= (ch == LAST_CH) ? '0 : ch + 1'b1;
			end
		end
	end

	// Result held until the next pixel completes
	always_ff @(posedge clk) begin
		if (accept && (ch == LAST_CH)) begin
			out_data <= acc_next;
		end
	end

endmodule

// ==== hw/conv1x1_top.sv ====
`timescale 1ns/100ps

module conv1x1_top import conv1x1_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	// APB slave
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	// Pixel stream
	input  logic      pix_valid,
	input  data_t     pix_data,
	output logic      pix_ready,
	// Dot product out
	output logic      out_valid,
	output acc_t      out_data
);

	logic      wt_push;
	logic      load_req;
	weight_t   wt_data;
	logic      weights_ready;
	logic      loading;
	logic      ovf_pulse;
	logic      load_err_pulse;
	fifo_cnt_t fifo_count;
	weight_t   w0, w1, w2, w3, w4, w5, w6, w7;

	//////////////////////////////////////////////////
	// Register block
	conv1x1_apb_regs apb_regs_inst (
		.clk            (clk),
		.reset          (reset),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.wt_push        (wt_push),
		.load_req       (load_req),
		.wt_data        (wt_data),
		.weights_ready  (weights_ready),
		.loading        (loading),
		.ovf_pulse      (ovf_pulse),
		.load_err_pulse (load_err_pulse),
		.fifo_count     (fifo_count)
	);

	// Weight staging, FIFO and weight file
	conv1x1_weight_buffer weight_buffer_inst (
		.clk            (clk),
		.reset          (reset),
		.wt_push        (wt_push),
		.load_req       (load_req),
		.wt_data        (wt_data),
		.w0             (w0),
		.w1             (w1),
		.w2             (w2),
		.w3             (w3),
		.w4             (w4),
		.w5             (w5),
		.w6             (w6),
		.w7             (w7),
		.weights_ready  (weights_ready),
		.loading        (loading),
		.ovf_pulse      (ovf_pulse),
		.load_err_pulse (load_err_pulse),
		.fifo_count     (fifo_count)
	);

	// Dot product datapath
	conv1x1_mac mac_inst (
		.clk           (clk),
		.reset         (reset),
		.pix_valid     (pix_valid),
		.weights_ready (weights_ready),
		.pix_data      (pix_data),
		.w0            (w0),
		.w1            (w1),
		.w2            (w2),
		.w3            (w3),
		.w4            (w4),
		.w5            (w5),
		.w6            (w6),
		.w7            (w7),
		.pix_ready     (pix_ready),
		.out_valid     (out_valid),
		.out_data      (out_data)
	);

endmodule

// ==== sim/conv1x1_chk.sv ====
`timescale 1ns/100ps

`include "conv1x1_params.svh"

module conv1x1_chk (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pslverr,
	input logic pix_ready,
	input logic loading,
	input logic out_valid
);

	//////////////////////////////////////////////////
	// Result pulse, pixel stall and APB error timing

	// A pixel needs NUM_CH accepts, so results never abut
	if (`NUM_CH > 1) begin : gen_single_pulse
		single_pulse: assert property (@(posedge clk) disable iff (reset)
			out_valid |=> !out_valid)
			else $error("out_valid high on two cycles in a row");
	end

	// No pixels taken while the weight file is being filled
	no_pix_while_loading: assert property (@(posedge clk) disable iff (reset)
		loading |-> !pix_ready)
		else $error("pix_ready high while weights are loading");

	// pslverr only in access phase
	slverr_in_access: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> (psel && penable))
		else $error("pslverr high outside an APB access phase");

endmodule

bind conv1x1_top conv1x1_chk conv1x1_chk_inst (
	.clk       (clk),
	.reset     (reset),
	.psel      (psel),
	.penable   (penable),
	.pslverr   (pslverr),
	.pix_ready (pix_ready),
	.loading   (loading),
	.out_valid (out_valid)
);

// ==== sim/conv1x1_tb.sv ====
`timescale 1ns/100ps

`include "conv1x1_params.svh"

module conv1x1_tb import conv1x1_pkg::*; ();

	// Cycles allowed per trace line before the watchdog fires
	localparam int CYCLES_PER_LINE = 40;

	logic      clk;
	logic      reset;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      pix_valid;
	data_t     pix_data;
	logic      pix_ready;
	logic      out_valid;
	acc_t      out_data;

	integer             fd;
	integer             r;
	integer             n_lines;
	integer             mismatch_cnt;
	integer             fault_cnt;
	logic [7:0]         cmd;
	logic [31:0]        arg_a;
	logic [31:0]        arg_b;
	logic signed [63:0] arg_v;
	logic [8*128-1:0]   line_buf;
	// Results seen on the output in arrival order
	acc_t               results [$];

	conv1x1_top conv1x1_top_inst (
		.clk       (clk),
		.reset     (reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.pix_ready (pix_ready),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Capture results mid-cycle away from the edge
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			results.push_back(out_data);
		end
	end

	//////////////////////////////////////////////////
	// APB helpers

	// Mapped registers are WEIGHT, CTRL and STATUS
	function automatic logic addr_mapped(input apb_addr_t a);
		return (a == `REG_WEIGHT) || (a == `REG_CTRL) || (a == `REG_STATUS);
	endfunction

	task automatic check_access(input apb_addr_t addr);
		logic exp_err;
		exp_err = !addr_mapped(addr);
		// pready stays high with no wait states
		assert (pready) else begin
			$display("mismatch at %0t: pready low in access phase to 0x%02h",
				$time, addr);
			mismatch_cnt++;
		end
		assert (pslverr == exp_err) else begin
			$display("Error at %0t: pslverr was %0b on access to address 0x%02h",
				$time, pslverr, addr);
			fault_cnt++;
		end
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		// Setup phase
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1;
		// Access phase completes on the next edge
		penable = 1'b1;
		#2;
		check_access(addr);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, input apb_data_t expected);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		// prdata settles combinationally in the access phase
		#2;
		check_access(addr);
		assert (prdata == expected) else begin
			$display("mismatch at %0t: read 0x%08h from 0x%02h, expected 0x%08h",
				$time, prdata, addr, expected);
			mismatch_cnt++;
		end
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Pixel stream and results

	// One element held until the DUT takes it
	task automatic drive_pixel(input data_t v);
		integer waited;
		waited    = 0;
		pix_valid = 1'b1;
		pix_data  = v;
		while (!pix_ready && waited < CYCLES_PER_LINE) begin
			@(posedge clk);
			#1;
			waited++;
		end
		assert (pix_ready) else begin
			$display("Error at %0t: pix_ready stayed low, element %0d not sent",
				$time, v);
			fault_cnt++;
		end
		if (pix_ready) begin
			@(posedge clk);
			#1;
		end
		pix_valid = 1'b0;
	endtask

	task automatic check_result(input logic signed [63:0] expected);
		integer waited;
		acc_t   got;
		waited = 0;
		while (results.size() == 0 && waited < CYCLES_PER_LINE) begin
			@(posedge clk);
			#1;
			waited++;
		end
		assert (results.size() != 0) else begin
			$display("Error at %0t: no result arrived for expected value %0d",
				$time, expected);
			fault_cnt++;
		end
		if (results.size() != 0) begin
			got = results.pop_front();
			assert (got == acc_t'(expected)) else begin
				$display("mismatch at %0t: result %0d, expected %0d",
					$time, got, expected);
				mismatch_cnt++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Watchdog sized from the trace length
	initial begin
		wait (n_lines > 0);
		repeat (n_lines * CYCLES_PER_LINE) @(posedge clk);
		$display("Timeout: trace not finished after %0d cycles",
			n_lines * CYCLES_PER_LINE);
		$display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, fault_cnt);
		$display("Simulation FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Trace player
	initial begin
		n_lines      = 0;
		mismatch_cnt = 0;
		fault_cnt    = 0;
		reset        = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		pix_valid    = 1'b0;
		pix_data     = '0;

		// First pass only counts lines
		fd = $fopen("sim/conv1x1_trace.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open sim/conv1x1_trace.txt");
			fault_cnt++;
		end else begin
			while (!$feof(fd)) begin
				r = $fgets(line_buf, fd);
				if (r > 0) begin
					n_lines++;
				end
			end
			$fclose(fd);
			fd = $fopen("sim/conv1x1_trace.txt", "r");
		end

		// Two cycles of reset
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		assert (!pix_ready) else begin
			$display("Error at %0t: pix_ready high before any weights loaded", $time);
			fault_cnt++;
		end

		if (fd != 0) begin
			while ($fscanf(fd, " %c", cmd) == 1) begin
				case (cmd)
					"#": r = $fgets(line_buf, fd);
					"W": begin
						r = $fscanf(fd, " %h %h", arg_a, arg_b);
						apb_write(arg_a[`APB_AW-1:0], arg_b);
					end
					"R": begin
						r = $fscanf(fd, " %h %h", arg_a, arg_b);
						apb_read(arg_a[`APB_AW-1:0], arg_b);
					end
					"P": begin
						r = $fscanf(fd, " %d", arg_v);
						drive_pixel(data_t'(arg_v));
					end
					"E": begin
						r = $fscanf(fd, " %d", arg_v);
						check_result(arg_v);
					end
					"L": begin
						r = $fscanf(fd, " %d", arg_a);
						repeat (arg_a) @(posedge clk);
						#1;
					end
					default: begin
						$display("Error: unknown trace command '%c'", cmd);
						fault_cnt++;
						r = $fgets(line_buf, fd);
					end
				endcase
			end
			$fclose(fd);
		end

		// Let a late result land before the final count
		repeat (4) @(posedge clk);
		assert (results.size() == 0) else begin
			$display("Error: %0d result(s) arrived that the trace did not expect",
				results.size());
			fault_cnt++;
		end

		$display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, fault_cnt);
		if (mismatch_cnt == 0 && fault_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== sim/conv1x1_trace.txt ====
# W addr data (hex) | R addr expected (hex) | P element (dec) | E expected sum (dec)
# L idle cycles (dec)
R 08 00000000
W 00 00007FFF
W 00 00008000
W 00 00000003
W 00 0000FFFE
W 00 00000010
W 00 00000000
W 00 00000001
W 00 0000FFFF
R 08 00000800
W 04 00000001
L 12
R 08 00000001
P 2
P 3
P -1
P 100
P -7
P 5
P 1000
P 9
P -32768
P 32767
P -32768
P 32767
P -32768
P 32767
P -32768
P 32767
E -32094
E -2148171773
W 00 00001111
W 00 00002222
W 00 00003333
W 04 00000001
L 4
R 08 00000309
P -1
P -1
P -1
P -1
P -1
P -1
P -1
P -1
E -16
W 00 00000004
W 00 00000005
W 00 00000006
W 00 00000007
W 00 00000008
W 00 00000009
W 00 0000000A
W 00 0000000B
W 00 0000000C
W 00 0000000D
W 00 0000000E
W 00 0000000F
W 00 00000010
W 00 00000011
R 08 0000100D
W 04 00000004
R 08 00001001
W 0C 00000000
R 10 00000000
R 08 00001001

// ==== conv1x1_top.f ====
+incdir+hw
hw/conv1x1_pkg.sv
hw/conv1x1_weight_fifo.sv
hw/conv1x1_weight_buffer.sv
hw/conv1x1_apb_regs.sv
hw/conv1x1_mac.sv
hw/conv1x1_top.sv
sim/conv1x1_chk.sv
sim/conv1x1_tb.sv

// ==== Bender.yml ====
package:
  name: conv1x1

sources:
  - include_dirs:
      - hw
    files:
      - hw/conv1x1_pkg.sv
      - hw/conv1x1_weight_fifo.sv
      - hw/conv1x1_weight_buffer.sv
      - hw/conv1x1_apb_regs.sv
      - hw/conv1x1_mac.sv
      - hw/conv1x1_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/conv1x1_chk.sv
      - sim/conv1x1_tb.sv
